/* verilog/fc_pkg.sv */
package fc_pkg;

  // primitive codes, 0..9 named sets, 10 unknown, 11 plain data
  typedef enum logic [3:0] {
    PRIM_IDLE    = 4'd0,
    PRIM_R_RDY   = 4'd1,
    PRIM_SOFI3   = 4'd2,
    PRIM_SOFN3   = 4'd3,
    PRIM_EOFN    = 4'd4,
    PRIM_EOFT    = 4'd5,
    PRIM_NOS     = 4'd6,
    PRIM_OLS     = 4'd7,
    PRIM_LR      = 4'd8,
    PRIM_LRR     = 4'd9,
    PRIM_UNKNOWN = 4'd10,
    PRIM_DATA    = 4'd11    // no K char, never counted
  } prim_t;

  localparam int PRIM_COUNTED = 11;  // named sets plus unknown

  // simplified port states
  typedef enum logic [2:0] {
    STATE_OFFLINE = 3'd0,
    STATE_LR      = 3'd1,   // link reset seen
    STATE_LRR     = 3'd2,   // link reset response seen
    STATE_LF      = 3'd3,   // link failure (NOS/OLS)
    STATE_AC      = 3'd4    // active, frames pass
  } state_t;

  // transceiver word, raw LE or aligned BE
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  datak;     // one K flag per byte lane
  } fc_word_t;

  // user side frame word
  typedef struct packed {
    logic [31:0] data;
    logic        sop;       // SOF word
    logic        eop;       // EOF word
  } fc_frame_t;

  // ordered sets in transmission order, K28.5 first
  localparam logic [31:0] IDLE_WORD  = 32'hBC95_B5B5;  // D21.4 D21.5 D21.5
  localparam logic [31:0] R_RDY_WORD = 32'hBC95_4A4A;  // D21.4 D10.2 D10.2
  localparam logic [31:0] SOFI3_WORD = 32'hBCB5_5656;  // D21.5 D22.2 D22.2
  localparam logic [31:0] SOFN3_WORD = 32'hBCB5_3636;  // D21.5 D22.1 D22.1
  localparam logic [31:0] EOFN_WORD  = 32'hBC95_D5D5;  // D21.4 D21.6 D21.6
  localparam logic [31:0] EOFT_WORD  = 32'hBC95_7575;  // D21.4 D21.3 D21.3
  localparam logic [31:0] NOS_WORD   = 32'hBC55_BF45;  // D21.2 D31.5 D5.2
  localparam logic [31:0] OLS_WORD   = 32'hBC35_8A55;  // D21.1 D10.4 D21.2
  localparam logic [31:0] LR_WORD    = 32'hBC49_BF49;  // D9.2 D31.5 D9.2
  localparam logic [31:0] LRR_WORD   = 32'hBC35_BF49;  // D21.1 D31.5 D9.2

  localparam logic [31:0] ALL_ONES_READ = 32'hFFFF_FFFF;  // unmapped register

endpackage

/* verilog/fc_rx_align.sv */
module fc_rx_align import fc_pkg::*; (
  input  logic       rx_clk,
  input  logic       rst_n,
  input  logic       raw_valid,
  input  fc_word_t   raw_word,        // LE, byte 0 first on the wire
  input  logic [3:0] pattern_detect,  // comma per byte lane
  input  logic       sync_ok,
  output logic       word_valid,
  output fc_word_t   word,            // BE, first byte in [31:24]
  output logic       aligned,
  output logic       comma_lane       // 0 lane 0, 1 lane 2
);

  logic     lane_q;     // latched comma lane
  logic     aligned_q;  // a comma seen since reset/sync loss
  fc_word_t prev_raw;   // upper half feeds lane 2 realignment
  logic     det_lane0;
  logic     det_lane2;
  logic     lane_now;   // lane applied to the current word
  logic     emit;
  fc_word_t le_word;    // realigned, still LE
  fc_word_t be_word;

  assign det_lane0 = raw_valid && (pattern_detect == 4'b0001);
  assign det_lane2 = raw_valid && (pattern_detect == 4'b0100);
  assign lane_now  = det_lane2 ? 1'b1 : (det_lane0 ? 1'b0 : lane_q);  // other patterns keep lane

  // a lane 2 comma only opens a set, its first full word comes next cycle
  assign emit = raw_valid && sync_ok && (aligned_q || det_lane0);

  always_comb begin
    if (lane_now) begin
      le_word.data  = {raw_word.data[15:0], prev_raw.data[31:16]};  // prev upper -> bytes 0..1
      le_word.datak = {raw_word.datak[1:0], prev_raw.datak[3:2]};
    end else begin
      le_word = raw_word;  // comma already in lane 0
    end
  end

  // byte reversal to transmission order, K flags follow their bytes
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      be_word.data[8*i +: 8] = le_word.data[8*(3-i) +: 8];
      be_word.datak[i]       = le_word.datak[3-i];
    end
  end

  always_ff @(posedge rx_clk) begin
    if (!rst_n) begin
      lane_q     <= 1'b0;
      aligned_q  <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= emit;
      if (!sync_ok) begin
        aligned_q <= 1'b0;  // wait for the next comma
      end else if (det_lane0 || det_lane2) begin
        aligned_q <= 1'b1;
        lane_q    <= lane_now;
      end
    end
  end

  always_ff @(posedge rx_clk) begin
    if (raw_valid) prev_raw <= raw_word;
    if (emit) word <= be_word;
  end

  assign aligned    = aligned_q;
  assign comma_lane = lane_q;

endmodule

/* verilog/fc_prim_decode.sv */
module fc_prim_decode import fc_pkg::*; (
  input  logic     rx_clk,
  input  logic     rst_n,
  input  logic     word_valid,
  input  fc_word_t word,        // BE aligned word
  output logic     prim_valid,
  output prim_t    prim,
  output fc_word_t prim_word    // word that produced prim
);

  prim_t os_match;  // ordered set lookup, K28.5 led words only
  prim_t code;

  always_comb begin
    case (word.data)
      IDLE_WORD:  os_match = PRIM_IDLE;
      R_RDY_WORD: os_match = PRIM_R_RDY;
      SOFI3_WORD: os_match = PRIM_SOFI3;
      SOFN3_WORD: os_match = PRIM_SOFN3;
      EOFN_WORD:  os_match = PRIM_EOFN;
      EOFT_WORD:  os_match = PRIM_EOFT;
      NOS_WORD:   os_match = PRIM_NOS;
      OLS_WORD:   os_match = PRIM_OLS;
      LR_WORD:    os_match = PRIM_LR;
      LRR_WORD:   os_match = PRIM_LRR;
      default:    os_match = PRIM_UNKNOWN;  // K led but no known set
    endcase
  end

  always_comb begin
    case (word.datak)
      4'b1000: code = os_match;       // K char in first byte only
      4'b0000: code = PRIM_DATA;      // plain data word
      default: code = PRIM_UNKNOWN;   // malformed K pattern
    endcase
  end

  always_ff @(posedge rx_clk) begin
    if (!rst_n) begin
      prim_valid <= 1'b0;
    end else begin
      prim_valid <= word_valid;
    end
  end

  always_ff @(posedge rx_clk) begin
    if (word_valid) begin
      prim      <= code;
      prim_word <= word;
    end
  end

endmodule

/* verilog/fc_link_rx.sv */
module fc_link_rx import fc_pkg::*; (
  input  logic      rx_clk,
  input  logic      rst_n,
  input  logic      sync_ok,
  input  logic      prim_valid,
  input  prim_t     prim,
  input  fc_word_t  prim_word,
  output state_t    link_state,
  output logic      frame_valid,
  output fc_frame_t frame
);

  state_t state_q;
  state_t state_next;
  logic   is_sof;
  logic   is_eof;
  logic   is_frame_word;  // SOF, data or EOF
  logic   deliver;

  // next state from the incoming primitive
  always_comb begin
    state_next = state_q;
    if (prim_valid) begin
      case (prim)
        PRIM_NOS, PRIM_OLS: state_next = STATE_LF;
        PRIM_LR:            state_next = STATE_LR;
        PRIM_LRR:           state_next = STATE_LRR;
        PRIM_IDLE, PRIM_R_RDY: begin
          if (state_q == STATE_LR || state_q == STATE_LRR) begin
            state_next = STATE_AC;  // reset handshake done
          end
        end
        default:            state_next = state_q;
      endcase
    end
  end

  assign is_sof        = (prim == PRIM_SOFI3) || (prim == PRIM_SOFN3);
  assign is_eof        = (prim == PRIM_EOFN) || (prim == PRIM_EOFT);
  assign is_frame_word = is_sof || is_eof || (prim == PRIM_DATA);

  // old state decides delivery, so the word that ends AC is still dropped
  assign deliver = prim_valid && sync_ok && (state_q == STATE_AC) && is_frame_word;

  always_ff @(posedge rx_clk) begin
    if (!rst_n) begin
      state_q     <= STATE_OFFLINE;
      frame_valid <= 1'b0;
    end else if (!sync_ok) begin
      state_q     <= STATE_OFFLINE;  // lost sync
      frame_valid <= 1'b0;
    end else begin
      state_q     <= state_next;
      frame_valid <= deliver;
    end
  end

  always_ff @(posedge rx_clk) begin
    if (deliver) begin
      frame.data <= prim_word.data;
      frame.sop  <= is_sof;
      frame.eop  <= is_eof;
    end
  end

  assign link_state = state_q;

endmodule

/* verilog/fc_prim_stats.sv */
module fc_prim_stats import fc_pkg::*; #(
  parameter int COUNT_WIDTH = 16  // counter width, up to 32
) (
  input  logic        rx_clk,
  input  logic        rst_n,
  input  logic        prim_valid,
  input  prim_t       prim,
  input  logic        aligned,
  input  logic        comma_lane,
  input  logic        sync_ok,
  input  state_t      link_state,
  input  logic        reg_rd,
  input  logic [4:0]  reg_addr,
  output logic        reg_rvalid,
  output logic [31:0] reg_rdata
);

  logic [COUNT_WIDTH-1:0] cnt [PRIM_COUNTED];  // one per code 0..10
  logic [31:0]            status;
  logic [31:0]            rd_mux;
  logic [3:0]             cnt_idx;             // low address bits in counter window

  assign status = {25'd0, link_state, 1'b0, comma_lane, sync_ok, aligned};

  // saturating counters, PRIM_DATA falls outside the array
  always_ff @(posedge rx_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < PRIM_COUNTED; i++) begin
        cnt[i] <= '0;
      end
    end else if (prim_valid) begin
      for (int i = 0; i < PRIM_COUNTED; i++) begin
        if (prim == prim_t'(i) && cnt[i] != '1) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign cnt_idx = reg_addr[3:0];

  // address map: 0 status, 16+n counter n
  always_comb begin
    rd_mux = ALL_ONES_READ;
    if (reg_addr == 5'd0) begin
      rd_mux = status;
    end else if (reg_addr[4] && (int'(cnt_idx) < PRIM_COUNTED)) begin
      rd_mux                  = '0;
      rd_mux[COUNT_WIDTH-1:0] = cnt[cnt_idx];  // zero extended
    end
  end

  always_ff @(posedge rx_clk) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd;
    end
  end

  always_ff @(posedge rx_clk) begin
    if (reg_rd) reg_rdata <= rd_mux;  // sees counts visible in the strobe cycle
  end

endmodule

/* verilog/fc_rx_top.sv */
module fc_rx_top import fc_pkg::*; #(
  parameter int COUNT_WIDTH = 16
) (
  input  logic        rx_clk,
  input  logic        rst_n,
  input  logic        raw_valid,
  input  fc_word_t    raw_word,
  input  logic [3:0]  pattern_detect,
  input  logic        sync_ok,
  output logic        frame_valid,
  output fc_frame_t   frame,
  input  logic        reg_rd,
  input  logic [4:0]  reg_addr,
  output logic        reg_rvalid,
  output logic [31:0] reg_rdata
);

  logic     word_valid;  // aligner -> decoder
  fc_word_t word;
  logic     aligned;
  logic     comma_lane;
  logic     prim_valid;  // decoder -> link and stats
  prim_t    prim;
  fc_word_t prim_word;
  state_t   link_state;

  fc_rx_align u_fc_rx_align (
    .rx_clk         (rx_clk),
    .rst_n          (rst_n),
    .raw_valid      (raw_valid),
    .raw_word       (raw_word),
    .pattern_detect (pattern_detect),
    .sync_ok        (sync_ok),
    .word_valid     (word_valid),
    .word           (word),
    .aligned        (aligned),
    .comma_lane     (comma_lane)
  );

  fc_prim_decode u_fc_prim_decode (
    .rx_clk     (rx_clk),
    .rst_n      (rst_n),
    .word_valid (word_valid),
    .word       (word),
    .prim_valid (prim_valid),
    .prim       (prim),
    .prim_word  (prim_word)
  );

  fc_link_rx u_fc_link_rx (
    .rx_clk      (rx_clk),
    .rst_n       (rst_n),
    .sync_ok     (sync_ok),
    .prim_valid  (prim_valid),
    .prim        (prim),
    .prim_word   (prim_word),
    .link_state  (link_state),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  fc_prim_stats #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_fc_prim_stats (
    .rx_clk     (rx_clk),
    .rst_n      (rst_n),
    .prim_valid (prim_valid),
    .prim       (prim),
    .aligned    (aligned),
    .comma_lane (comma_lane),
    .sync_ok    (sync_ok),
    .link_state (link_state),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_rvalid (reg_rvalid),
    .reg_rdata  (reg_rdata)
  );

endmodule

/* verification/fc_rx_tb.sv */
module fc_rx_tb import fc_pkg::*; ();

  logic        rx_clk;
  logic        rst_n;
  logic        raw_valid;
  fc_word_t    raw_word;
  logic [3:0]  pattern_detect;
  logic        sync_ok;
  logic        frame_valid;
  fc_frame_t   frame;
  logic        reg_rd;
  logic [4:0]  reg_addr;
  logic        reg_rvalid;
  logic [31:0] reg_rdata;

  logic [31:0] stim [0:511];  // four fields per command line
  fc_frame_t   frame_q [$];   // frames seen at the output
  int          test_errors;   // errors in the running test
  int          total_errors;
  int          tests_run;
  int          tests_failed;

  fc_rx_top #(
    .COUNT_WIDTH (16)
  ) u_fc_rx_top (
    .rx_clk         (rx_clk),
    .rst_n          (rst_n),
    .raw_valid      (raw_valid),
    .raw_word       (raw_word),
    .pattern_detect (pattern_detect),
    .sync_ok        (sync_ok),
    .frame_valid    (frame_valid),
    .frame          (frame),
    .reg_rd         (reg_rd),
    .reg_addr       (reg_addr),
    .reg_rvalid     (reg_rvalid),
    .reg_rdata      (reg_rdata)
  );

  initial rx_clk = 1'b0;
  always #50 rx_clk = ~rx_clk;  // 100 unit period

  // frame monitor, popped by expect commands
  always @(posedge rx_clk) begin
    if (rst_n && frame_valid) frame_q.push_back(frame);
  end

  task automatic log_error(input string msg);
    $display("error: %s", msg);
    test_errors++;
    total_errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errors++;
      total_errors++;
    end
  endtask

  // one strobe, then a random gap with the inputs quiet
  task automatic send_word(input logic [31:0] data, input logic [3:0] datak,
                           input logic [3:0] pattern);
    int gap;
    raw_valid      = 1'b1;
    raw_word.data  = data;   // LE, byte 0 in [7:0]
    raw_word.datak = datak;
    pattern_detect = pattern;
    @(negedge rx_clk);
    raw_valid      = 1'b0;
    pattern_detect = 4'b0000;
    gap = $urandom_range(3, 0);
    repeat (gap) @(negedge rx_clk);
  endtask

  task automatic read_reg(input logic [4:0] addr, input logic [31:0] exp);
    int waited;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge rx_clk);
    reg_rd = 1'b0;
    waited = 0;
    while (!reg_rvalid && waited < 50) begin
      @(negedge rx_clk);
      waited++;
    end
    if (!reg_rvalid) begin
      log_error($sformatf("no read response from address %h", addr));
    end else begin
      check_value($sformatf("reg_rdata[%h]", addr), reg_rdata, exp);
    end
  endtask

  task automatic expect_frame(input logic [31:0] data, input logic sop, input logic eop);
    int        waited;
    fc_frame_t got;
    waited = 0;
    while (frame_q.size() == 0 && waited < 50) begin
      @(negedge rx_clk);
      waited++;
    end
    if (frame_q.size() == 0) begin
      log_error("no frame arrived within 50 cycles");
    end else begin
      got = frame_q.pop_front();
      check_value("frame.data", got.data, data);
      check_value("frame.sop", got.sop, sop);
      check_value("frame.eop", got.eop, eop);
    end
  endtask

  task automatic end_test(input int num);
    if (frame_q.size() != 0) begin
      log_error($sformatf("%0d frame(s) delivered beyond those expected", frame_q.size()));
      frame_q.delete();
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d passed", num);
    end else begin
      $display("test %0d failed with %0d error(s)", num, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    int          pc;
    int          seed;
    int          rnd;
    logic [31:0] cmd;
    logic        running;
    seed = 32'hffdbb6f9;
    rnd  = $urandom(seed);  // seeds the idle gap generator
    rst_n          = 1'b0;
    raw_valid      = 1'b0;
    raw_word       = '0;
    pattern_detect = 4'b0000;
    sync_ok        = 1'b0;
    reg_rd         = 1'b0;
    reg_addr       = 5'd0;
    test_errors    = 0;
    total_errors   = 0;
    tests_run      = 0;
    tests_failed   = 0;
    $readmemh("verification/fc_rx_stimulus.txt", stim);
    repeat (4) @(posedge rx_clk);
    @(negedge rx_clk);
    rst_n = 1'b1;
    pc      = 0;
    running = 1'b1;
    while (running && pc <= 508) begin
      cmd = stim[pc];
      case (cmd)
        32'd0: running = 1'b0;  // end of file
        32'd1: send_word(stim[pc+1], stim[pc+2][3:0], stim[pc+3][3:0]);
        32'd2: sync_ok = stim[pc+1][0];
        32'd3: repeat (stim[pc+1]) @(negedge rx_clk);
        32'd4: read_reg(stim[pc+1][4:0], stim[pc+2]);
        32'd5: expect_frame(stim[pc+1], stim[pc+2][0], stim[pc+3][0]);
        32'd6: end_test(stim[pc+1]);
        default: begin
          log_error($sformatf("unknown command %h in stimulus file", cmd));
          running = 1'b0;
        end
      endcase
      pc += 4;
    end
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0 && tests_run != 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
verilog/fc_pkg.sv
verilog/fc_rx_align.sv
verilog/fc_prim_decode.sv
verilog/fc_link_rx.sv
verilog/fc_prim_stats.sv
verilog/fc_rx_top.sv
verification/fc_rx_tb.sv

/* verification/fc_rx_stimulus.txt */
// cmd a b c, hex: 1 send data datak pattern, 2 sync_ok, 3 idle n, 4 read addr value
// 5 frame data sop eop, 6 end test n, 0 stop; raw words are LE, frames BE
2 1 0 0
// test 1: LR, comma on lane 0
1 49BF49BC 1 1
3 6 0 0
4 00 00000013 0
4 18 00000001 0
6 1 0 0
// test 2: comma on lane 2, LRR then IDLE split across words
1 35BC0000 4 4
1 95BC49BF 4 4
1 95BCB5B5 4 4
3 6 0 0
4 00 00000047 0
4 19 00000001 0
4 10 00000001 0
6 2 0 0
// test 3: SOFi3, two data words, EOFn, IDLE in AC
1 5656B5BC 1 1
1 44332211 0 0
1 EFBEADDE 0 0
1 D5D595BC 1 1
1 B5B595BC 1 1
5 BCB55656 1 0
5 11223344 0 0
5 DEADBEEF 0 0
5 BC95D5D5 0 1
3 6 0 0
6 3 0 0
// test 4: R_RDY twice, unknown K set, malformed K flags, unmapped reads
1 4A4A95BC 1 1
1 4A4A95BC 1 1
1 563412BC 1 1
1 00000000 3 0
3 6 0 0
4 10 00000002 0
4 11 00000002 0
4 12 00000001 0
4 13 00000000 0
4 14 00000001 0
4 1A 00000002 0
4 1B FFFFFFFF 0
4 05 FFFFFFFF 0
6 4 0 0
// test 5: NOS, data dropped in LF, then loss of sync
1 45BF55BC 1 1
1 78563412 0 0
3 6 0 0
4 00 00000033 0
4 16 00000001 0
2 0 0 0
3 2 0 0
4 00 00000000 0
6 5 0 0
0 0 0 0
